// File: common/i2c_defines.svh
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// bus and register widths
`define I2C_DATA_W      8
`define I2C_DEV_ADDR_W  7
`define I2C_DIV_W       16

// byte engine commands
`define I2C_CMD_START   3'd0
`define I2C_CMD_RESTART 3'd1  // release SCL high, then start
`define I2C_CMD_WRITE   3'd2  // byte out, ACK in
`define I2C_CMD_READ    3'd3  // byte in, NACK out
`define I2C_CMD_STOP    3'd4

// transaction sequencer states
`define SEQ_IDLE        4'd0
`define SEQ_START       4'd1
`define SEQ_ADDR_W      4'd2
`define SEQ_REG         4'd3
`define SEQ_DATA        4'd4
`define SEQ_RESTART     4'd5
`define SEQ_ADDR_R      4'd6
`define SEQ_READ        4'd7
`define SEQ_STOP        4'd8

// quarter-bit phases, one tick each
`define PH_0            2'd0  // SDA setup, SCL low
`define PH_1            2'd1  // SCL released
`define PH_2            2'd2  // wait for SCL high
`define PH_3            2'd3  // sample, SCL low

`endif

// File: common/i2c_pkg.sv
`default_nettype none
`include "i2c_defines.svh"

package i2c_pkg;

    typedef struct packed {
        logic [`I2C_DEV_ADDR_W-1:0] dev_addr;
        logic                       rw;       // 1 = read
    } addr_fields_t;

    // first byte after a start, or any plain byte on the wire
    typedef union packed {
        logic [`I2C_DATA_W-1:0] raw;
        addr_fields_t           fields;
    } addr_byte_u;

endpackage

`default_nettype wire

// File: source/i2c_tick_gen.sv
`default_nettype none
`include "i2c_defines.svh"

module i2c_tick_gen (
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire [`I2C_DIV_W-1:0]  i_divider,
    output logic                  o_tick
);

    logic [`I2C_DIV_W-1:0] count;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count <= '0;
        end else if (count >= i_divider) begin  // also recovers if divider drops
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign o_tick = (count == i_divider);

    // with a nonzero divider ticks are always separated by idle clocks
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_tick |=> (!o_tick || i_divider == '0));

endmodule

`default_nettype wire

// File: source/i2c_byte_engine.sv
`default_nettype none
`include "i2c_defines.svh"

module i2c_byte_engine (
    input  wire                       i_clk,
    input  wire                       i_rst,
    input  wire                       i_tick,
    input  wire                       i_cmd_valid,
    input  wire  [2:0]                i_cmd,
    input  wire  i2c_pkg::addr_byte_u i_tx_byte,
    input  wire                       i_scl,
    input  wire                       i_sda,
    output logic                      o_done,
    output logic                      o_ack_ok,
    output logic [`I2C_DATA_W-1:0]    o_rx_byte,
    output logic                      o_scl,
    output logic                      o_scl_oe,
    output logic                      o_sda,
    output logic                      o_sda_oe
);

    logic                   active;
    logic [2:0]             cmd_r;
    logic [2:0]             cur_cmd;
    logic [1:0]             phase;
    logic [3:0]             bit_cnt;
    logic [`I2C_DATA_W-1:0] shift;
    logic [`I2C_DATA_W-1:0] cur_shift;
    logic                   go;
    logic                   ack_slot;
    logic                   last_bit;
    logic                   start_like;

    // the accept tick already runs PH_0 of the first bit
    assign go         = i_tick && (active || i_cmd_valid);
    assign cur_cmd    = active ? cmd_r : i_cmd;
    assign cur_shift  = active ? shift : i_tx_byte.raw;
    assign ack_slot   = (bit_cnt == 4'(`I2C_DATA_W));  // ninth bit, ACK or NACK
    assign start_like = (cur_cmd == `I2C_CMD_START) ||
                        (cur_cmd == `I2C_CMD_RESTART && bit_cnt == 4'd1);

    always_comb begin
        case (cur_cmd)
            `I2C_CMD_WRITE, `I2C_CMD_READ: last_bit = ack_slot;
            `I2C_CMD_RESTART:              last_bit = (bit_cnt == 4'd1);
            default:                       last_bit = 1'b1;
        endcase
    end

    assign o_done    = i_tick && (phase == `PH_3) && last_bit;
    assign o_ack_ok  = (cmd_r != `I2C_CMD_WRITE) || !i_sda;
    assign o_rx_byte = shift;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            active   <= 1'b0;
            cmd_r    <= `I2C_CMD_STOP;
            phase    <= `PH_0;
            bit_cnt  <= '0;
            o_scl    <= 1'b1;
            o_scl_oe <= 1'b0;
            o_sda    <= 1'b1;
            o_sda_oe <= 1'b0;
        end else if (go) begin
            if (!active) begin
                active <= 1'b1;
                cmd_r  <= i_cmd;
            end
            case (phase)
                `PH_0: begin
                    phase <= `PH_1;
                    case (cur_cmd)
                        `I2C_CMD_START: begin
                            o_scl_oe <= 1'b1;
                            o_sda_oe <= 1'b1;
                        end
                        `I2C_CMD_RESTART: begin
                            o_sda_oe <= 1'b1;  // SDA back high before SCL rises
                            o_sda    <= 1'b1;
                        end
                        `I2C_CMD_WRITE: begin
                            if (ack_slot) begin
                                o_sda_oe <= 1'b0;  // target drives ACK
                                o_sda    <= 1'b1;
                            end else begin
                                o_sda_oe <= 1'b1;
                                o_sda    <= cur_shift[`I2C_DATA_W-1];
                            end
                        end
                        `I2C_CMD_READ: begin
                            o_sda_oe <= ack_slot;  // NACK on the ninth bit
                            o_sda    <= 1'b1;
                        end
                        `I2C_CMD_STOP: begin
                            o_sda_oe <= 1'b1;
                            o_sda    <= 1'b0;
                        end
                        default: begin
                            o_sda_oe <= o_sda_oe;
                        end
                    endcase
                end
                `PH_1: begin
                    phase <= `PH_2;
                    if (start_like) begin
                        o_sda <= 1'b0;  // falling SDA under high SCL
                    end else begin
                        o_scl <= 1'b1;
                    end
                end
                `PH_2: begin
                    if (start_like || i_scl) begin  // target may stretch here
                        phase <= `PH_3;
                    end
                end
                `PH_3: begin
                    phase <= `PH_0;
                    if (last_bit) begin
                        active  <= 1'b0;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                    case (cur_cmd)
                        `I2C_CMD_STOP: begin
                            o_sda    <= 1'b1;
                            o_sda_oe <= 1'b0;
                            o_scl_oe <= 1'b0;
                        end
                        `I2C_CMD_WRITE: begin
                            if (ack_slot && i_sda) begin
                                // no ACK, let go of the bus
                                o_scl_oe <= 1'b0;
                                o_sda_oe <= 1'b0;
                            end else begin
                                o_scl <= 1'b0;
                            end
                        end
                        `I2C_CMD_RESTART: begin
                            if (start_like) begin
                                o_scl <= 1'b0;
                            end
                        end
                        default: o_scl <= 1'b0;
                    endcase
                end
                default: phase <= `PH_0;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (go && !active) begin
            shift <= i_tx_byte.raw;
        end else if (go && phase == `PH_3 && !ack_slot) begin
            if (cmd_r == `I2C_CMD_READ) begin
                shift <= {shift[`I2C_DATA_W-2:0], i_sda};  // MSB first
            end else begin
                shift <= {shift[`I2C_DATA_W-2:0], 1'b0};
            end
        end
    end

    // done only closes a command that was handed over on a tick
    assert property (@(posedge i_clk) disable iff (i_rst) o_done |-> active);
    assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(active) |-> $past(i_cmd_valid && i_tick));

    // data bits only move while SCL is low
    assert property (@(posedge i_clk) disable iff (i_rst)
        (o_scl && $past(o_scl) && $changed(o_sda)) |->
            ($past(cmd_r) != `I2C_CMD_WRITE && $past(cmd_r) != `I2C_CMD_READ));

endmodule

`default_nettype wire

// File: source/i2c_sequencer.sv
`default_nettype none
`include "i2c_defines.svh"

module i2c_sequencer (
    input  wire                           i_clk,
    input  wire                           i_rst,
    input  wire                           i_tick,
    input  wire                           i_enable,
    input  wire                           i_rw,
    input  wire  [`I2C_DATA_W-1:0]        i_data,
    input  wire  [`I2C_DATA_W-1:0]        i_reg_addr,
    input  wire  [`I2C_DEV_ADDR_W-1:0]    i_device_addr,
    input  wire                           i_done,
    input  wire                           i_ack_ok,
    input  wire  [`I2C_DATA_W-1:0]        i_rx_byte,
    output logic                          o_cmd_valid,
    output logic [2:0]                    o_cmd,
    output i2c_pkg::addr_byte_u           o_tx_byte,
    output logic [`I2C_DATA_W-1:0]        o_data,
    output logic                          o_busy
);

    import i2c_pkg::*;

    logic [3:0]                 state;
    logic [3:0]                 next_state;
    logic                       pending;      // i_enable seen on an idle tick
    logic                       outstanding;  // engine is working on a command
    logic                       cmd_done;
    logic                       issue;
    logic [2:0]                 next_cmd;
    addr_byte_u                 next_tx;
    logic                       rw_r;
    logic [`I2C_DATA_W-1:0]     data_r;
    logic [`I2C_DATA_W-1:0]     reg_r;
    logic [`I2C_DEV_ADDR_W-1:0] dev_r;

    assign cmd_done = i_done && outstanding;

    always_comb begin
        next_state = state;
        case (state)
            `SEQ_IDLE:    if (i_tick && pending) next_state = `SEQ_START;
            `SEQ_START:   if (cmd_done) next_state = `SEQ_ADDR_W;
            `SEQ_ADDR_W:  if (cmd_done) next_state = i_ack_ok ? `SEQ_REG : `SEQ_IDLE;
            `SEQ_REG: begin
                if (cmd_done) begin
                    if (!i_ack_ok) begin
                        next_state = `SEQ_IDLE;
                    end else begin
                        next_state = rw_r ? `SEQ_RESTART : `SEQ_DATA;
                    end
                end
            end
            `SEQ_DATA:    if (cmd_done) next_state = i_ack_ok ? `SEQ_STOP : `SEQ_IDLE;
            `SEQ_RESTART: if (cmd_done) next_state = `SEQ_ADDR_R;
            `SEQ_ADDR_R:  if (cmd_done) next_state = i_ack_ok ? `SEQ_READ : `SEQ_IDLE;
            `SEQ_READ:    if (cmd_done) next_state = `SEQ_STOP;
            `SEQ_STOP:    if (cmd_done) next_state = `SEQ_IDLE;
            default:      next_state = `SEQ_IDLE;
        endcase
    end

    // every state but idle owns exactly one engine command
    assign issue = (next_state != state) && (next_state != `SEQ_IDLE);

    always_comb begin
        next_cmd    = `I2C_CMD_STOP;
        next_tx.raw = '1;
        case (next_state)
            `SEQ_START:   next_cmd = `I2C_CMD_START;
            `SEQ_ADDR_W: begin
                next_cmd                = `I2C_CMD_WRITE;
                next_tx.fields.dev_addr = dev_r;
                next_tx.fields.rw       = 1'b0;
            end
            `SEQ_REG: begin
                next_cmd    = `I2C_CMD_WRITE;
                next_tx.raw = reg_r;
            end
            `SEQ_DATA: begin
                next_cmd    = `I2C_CMD_WRITE;
                next_tx.raw = data_r;
            end
            `SEQ_RESTART: next_cmd = `I2C_CMD_RESTART;
            `SEQ_ADDR_R: begin
                next_cmd                = `I2C_CMD_WRITE;
                next_tx.fields.dev_addr = dev_r;
                next_tx.fields.rw       = 1'b1;
            end
            `SEQ_READ:    next_cmd = `I2C_CMD_READ;
            default:      next_cmd = `I2C_CMD_STOP;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= `SEQ_IDLE;
            pending     <= 1'b0;
            outstanding <= 1'b0;
            o_cmd_valid <= 1'b0;
            o_cmd       <= `I2C_CMD_STOP;
            o_busy      <= 1'b0;
            o_data      <= '0;
        end else begin
            state <= next_state;
            if (state == `SEQ_IDLE && i_tick) begin
                pending <= pending ? 1'b0 : i_enable;
            end
            if (issue) begin
                o_cmd_valid <= 1'b1;
                o_cmd       <= next_cmd;
            end else if (i_tick) begin
                o_cmd_valid <= 1'b0;  // held for one tick period
            end
            if (o_cmd_valid && i_tick) begin
                outstanding <= 1'b1;
            end else if (i_done) begin
                outstanding <= 1'b0;
            end
            if (state == `SEQ_START && i_tick) begin
                o_busy <= 1'b1;
            end else if (state != `SEQ_IDLE && next_state == `SEQ_IDLE) begin
                o_busy <= 1'b0;  // finished or aborted on NACK
            end
            if (cmd_done && state == `SEQ_READ) begin
                o_data <= i_rx_byte;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_tx_byte <= next_tx;
        end
        if (state == `SEQ_IDLE && i_tick && pending) begin
            rw_r   <= i_rw;
            data_r <= i_data;
            reg_r  <= i_reg_addr;
            dev_r  <= i_device_addr;
        end
    end

    // one command at a time across the engine boundary
    assert property (@(posedge i_clk) disable iff (i_rst) o_cmd_valid |-> !outstanding);

endmodule

`default_nettype wire

// File: source/i2c_master.sv
`default_nettype none
`include "i2c_defines.svh"

module i2c_master (
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_enable,
    input  wire                         i_rw,            // 1 = read
    input  wire  [`I2C_DATA_W-1:0]      i_data,
    input  wire  [`I2C_DATA_W-1:0]      i_reg_addr,
    input  wire  [`I2C_DEV_ADDR_W-1:0]  i_device_addr,
    input  wire  [`I2C_DIV_W-1:0]       i_divider,
    output logic [`I2C_DATA_W-1:0]      o_data,
    output logic                        o_busy,
    input  wire                         i_scl,
    output logic                        o_scl,
    output logic                        o_scl_oe,
    input  wire                         i_sda,
    output logic                        o_sda,
    output logic                        o_sda_oe
);

    import i2c_pkg::*;

    wire                         tick;
    wire                         cmd_valid;
    wire  [2:0]                  cmd;
    wire  addr_byte_u            tx_byte;
    wire                         done;
    wire                         ack_ok;
    wire  [`I2C_DATA_W-1:0]      rx_byte;

    i2c_tick_gen u_tick_gen (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_divider (i_divider),
        .o_tick    (tick)
    );

    i2c_sequencer u_sequencer (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_tick        (tick),
        .i_enable      (i_enable),
        .i_rw          (i_rw),
        .i_data        (i_data),
        .i_reg_addr    (i_reg_addr),
        .i_device_addr (i_device_addr),
        .i_done        (done),
        .i_ack_ok      (ack_ok),
        .i_rx_byte     (rx_byte),
        .o_cmd_valid   (cmd_valid),
        .o_cmd         (cmd),
        .o_tx_byte     (tx_byte),
        .o_data        (o_data),
        .o_busy        (o_busy)
    );

    i2c_byte_engine u_byte_engine (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_tick      (tick),
        .i_cmd_valid (cmd_valid),
        .i_cmd       (cmd),
        .i_tx_byte   (tx_byte),
        .i_scl       (i_scl),
        .i_sda       (i_sda),
        .o_done      (done),
        .o_ack_ok    (ack_ok),
        .o_rx_byte   (rx_byte),
        .o_scl       (o_scl),
        .o_scl_oe    (o_scl_oe),
        .o_sda       (o_sda),
        .o_sda_oe    (o_sda_oe)
    );

endmodule

`default_nettype wire

// File: bench/i2c_clock_gen.sv
`default_nettype none

module i2c_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;  // 40 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clk);
        #2;
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/i2c_target_model.sv
`default_nettype none
`include "i2c_defines.svh"

module i2c_target_model #(
    parameter logic [`I2C_DEV_ADDR_W-1:0] DEV_ADDR = 7'h42
) (
    input  wire        i_clk,
    input  wire        i_rst,
    input  wire  [7:0] i_stretch,  // clocks of SCL low after each falling edge
    input  wire        i_scl,
    input  wire        i_sda,
    output logic       o_scl_low,
    output logic       o_sda_low
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int st_idle = 0;
    localparam int st_addr = 1;
    localparam int st_reg  = 2;
    localparam int st_data = 3;
    localparam int st_tx   = 4;

    logic [`I2C_DATA_W-1:0] regs [0:255];
    logic [`I2C_DATA_W-1:0] shift_in;
    logic [`I2C_DATA_W-1:0] tx;
    logic [`I2C_DATA_W-1:0] reg_ptr;
    logic [7:0]             hold;
    logic                   scl_q;
    logic                   sda_q;
    logic                   read_mode;
    int                     state;
    int                     bit_cnt;

    assign o_scl_low = (hold != 8'd0);

    always @(posedge i_clk) begin
        if (i_rst) begin
            for (int a = 0; a < 256; a++) begin
                regs[a] <= 8'(a) ^ 8'h6c;
            end
            state     <= st_idle;
            bit_cnt   <= 0;
            hold      <= 8'd0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            read_mode <= 1'b0;
            reg_ptr   <= '0;
            o_sda_low <= 1'b0;
        end else begin
            scl_q <= i_scl;
            sda_q <= i_sda;
            if (hold != 8'd0) hold <= hold - 8'd1;
            if (i_scl && scl_q && sda_q && !i_sda) begin  // start or repeated start
                state     <= st_addr;
                bit_cnt   <= 0;
                o_sda_low <= 1'b0;
            end else if (i_scl && scl_q && !sda_q && i_sda) begin  // stop
                state     <= st_idle;
                bit_cnt   <= 0;
                o_sda_low <= 1'b0;
            end else if (i_scl && !scl_q && state != st_idle) begin
                if (bit_cnt < 8 && state != st_tx) shift_in <= {shift_in[6:0], i_sda};
                bit_cnt <= bit_cnt + 1;
            end else if (!i_scl && scl_q) begin
                hold <= i_stretch;
                if (state == st_tx) begin
                    if (bit_cnt < 8) o_sda_low <= !tx[7 - bit_cnt];
                    else if (bit_cnt == 8) o_sda_low <= 1'b0;  // master answers
                    else state <= st_idle;
                end else if (bit_cnt == 8) begin
                    case (state)
                        st_addr: begin
                            if (shift_in[7:1] == DEV_ADDR) begin
                                o_sda_low <= 1'b1;
                                read_mode <= shift_in[0];
                            end else begin
                                state <= st_idle;  // not ours, stay off the bus
                            end
                        end
                        st_reg: begin
                            reg_ptr   <= shift_in;
                            o_sda_low <= 1'b1;
                        end
                        st_data: begin
                            regs[reg_ptr] <= shift_in;
                            o_sda_low     <= 1'b1;
                        end
                        default: ;
                    endcase
                end else if (bit_cnt == 9) begin
                    o_sda_low <= 1'b0;
                    bit_cnt   <= 0;
                    case (state)
                        st_addr: begin
                            if (read_mode) begin
                                state     <= st_tx;
                                tx        <= regs[reg_ptr];
                                o_sda_low <= !regs[reg_ptr][7];
                            end else begin
                                state <= st_reg;
                            end
                        end
                        st_reg:  state <= st_data;
                        default: state <= st_idle;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/i2c_master_tb.sv
`default_nettype none
`include "i2c_defines.svh"

module i2c_master_tb;

    timeunit 1ns;
    timeprecision 1ps;

    wire                        clk;
    wire                        rst;
    logic                       enable;
    logic                       rw;
    logic [`I2C_DATA_W-1:0]     data;
    logic [`I2C_DATA_W-1:0]     reg_addr;
    logic [`I2C_DEV_ADDR_W-1:0] device_addr;
    logic [`I2C_DIV_W-1:0]      divider;
    logic [7:0]                 stretch;
    wire  [`I2C_DATA_W-1:0]     rd_data;
    wire                        busy;
    wire                        scl_out;
    wire                        scl_oe;
    wire                        sda_out;
    wire                        sda_oe;
    wire                        scl_low;
    wire                        sda_low;
    wire                        bus_scl;
    wire                        bus_sda;

    logic [7:0]                 op_q[$];
    logic [`I2C_DEV_ADDR_W-1:0] dev_q[$];
    logic [`I2C_DATA_W-1:0]     reg_q[$];
    logic [`I2C_DATA_W-1:0]     wdata_q[$];
    logic [`I2C_DIV_W-1:0]      div_q[$];
    int                         stretch_q[$];
    logic                       ack_q[$];
    logic [`I2C_DATA_W-1:0]     exp_q[$];

    int                         seed = 98162;
    int                         cycles;
    int                         limit;
    int                         max_div;
    int                         high_cnt;
    logic                       scl_prev;
    logic [`I2C_DATA_W-1:0]     last_read;

    // wired-AND with pull-up
    assign bus_scl = (scl_oe ? scl_out : 1'b1) & !scl_low;
    assign bus_sda = (sda_oe ? sda_out : 1'b1) & !sda_low;

    i2c_clock_gen u_clock (.o_clk(clk), .o_rst(rst));

    i2c_master i_dut (
        .i_clk(clk), .i_rst(rst), .i_enable(enable), .i_rw(rw),
        .i_data(data), .i_reg_addr(reg_addr), .i_device_addr(device_addr),
        .i_divider(divider), .o_data(rd_data), .o_busy(busy),
        .i_scl(bus_scl), .o_scl(scl_out), .o_scl_oe(scl_oe),
        .i_sda(bus_sda), .o_sda(sda_out), .o_sda_oe(sda_oe)
    );

    i2c_target_model #(.DEV_ADDR(7'h42)) u_target (
        .i_clk(clk), .i_rst(rst), .i_stretch(stretch),
        .i_scl(bus_scl), .i_sda(bus_sda), .o_scl_low(scl_low), .o_sda_low(sda_low)
    );

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_data(input logic [`I2C_DATA_W-1:0] got,
                              input logic [`I2C_DATA_W-1:0] exp);
        if (got !== exp) report_error($sformatf("o_data is %h, expected %h", got, exp));
    endtask

    task automatic check_reg(input logic [`I2C_DATA_W-1:0] addr,
                             input logic [`I2C_DATA_W-1:0] exp);
        logic [`I2C_DATA_W-1:0] got;
        got = u_target.regs[addr];
        if (got !== exp) begin
            report_error($sformatf("target register %h holds %h, expected %h", addr, got, exp));
        end
    endtask

    task automatic check_scl_high(input int clocks, input logic [`I2C_DIV_W-1:0] div);
        if (clocks < int'(div) + 1) begin
            report_error($sformatf("SCL high for %0d clocks with divider %0d", clocks, div));
        end
    endtask

    task automatic expect_bus_free();
        if (bus_scl !== 1'b1 || bus_sda !== 1'b1 || scl_oe !== 1'b0 || sda_oe !== 1'b0) begin
            report_error($sformatf("bus not released, scl %b sda %b", bus_scl, bus_sda));
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        string skip;
        logic [7:0] op;
        int    dev, rg, wd, dv, st, ack, ex;
        fd = $fopen("bench/i2c_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/i2c_stimulus.txt");
            $display("Verification failed");
            $fatal(1, "no stimulus");
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    n = $fgets(skip, fd);  // column notes
                end else begin
                    n = $fscanf(fd, "%h %h %h %d %d %d %h", dev, rg, wd, dv, st, ack, ex);
                    op_q.push_back(op);
                    dev_q.push_back(dev[`I2C_DEV_ADDR_W-1:0]);
                    reg_q.push_back(rg[`I2C_DATA_W-1:0]);
                    wdata_q.push_back(wd[`I2C_DATA_W-1:0]);
                    div_q.push_back(dv[`I2C_DIV_W-1:0]);
                    stretch_q.push_back(st);
                    ack_q.push_back(ack != 0);
                    exp_q.push_back(ex[`I2C_DATA_W-1:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_line(input int i);
        int st;
        st = stretch_q[i];
        if (st < 0) st = $random(seed) & 15;
        @(posedge clk);
        #2;
        enable      = 1'b1;
        rw          = (op_q[i] == "R");
        device_addr = dev_q[i];
        reg_addr    = reg_q[i];
        data        = wdata_q[i];
        divider     = div_q[i];
        stretch     = st[7:0];
        do begin
            @(posedge clk);
            #2;
        end while (!busy);
        enable = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (busy);
        expect_bus_free();
        if (op_q[i] == "R" && ack_q[i]) begin
            check_data(rd_data, exp_q[i]);
            last_read = exp_q[i];
        end else begin
            check_reg(reg_q[i], exp_q[i]);  // also the untouched register after a NACK
            check_data(rd_data, last_read);
        end
    endtask

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run did not end within %0d clock cycles", limit);
            $display("Verification failed");
            $fatal(1, "simulation timed out");
        end
    end

    // SCL high time, sampled away from the active edge
    always @(negedge clk) begin
        if (bus_scl === 1'b1) begin
            high_cnt = high_cnt + 1;
        end else begin
            if (scl_prev && !rst) check_scl_high(high_cnt, divider);
            high_cnt = 0;
        end
        scl_prev = (bus_scl === 1'b1);
    end

    initial begin
        enable      = 1'b0;
        rw          = 1'b0;
        data        = '0;
        reg_addr    = '0;
        device_addr = '0;
        divider     = '0;
        stretch     = '0;
        cycles      = 0;
        limit       = 0;
        high_cnt    = 0;
        scl_prev    = 1'b1;
        last_read   = '0;
        load_stimulus();
        max_div = 0;
        foreach (div_q[k]) begin
            if (int'(div_q[k]) > max_div) max_div = int'(div_q[k]);
        end
        limit = op_q.size() * (max_div + 1) * 4 * 40 * 2;
        do begin
            @(posedge clk);
            #2;
        end while (rst);
        check_data(rd_data, '0);
        expect_bus_free();
        for (int i = 0; i < op_q.size(); i++) begin
            run_line(i);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: i2c_master.f
+incdir+common
common/i2c_pkg.sv
source/i2c_tick_gen.sv
source/i2c_byte_engine.sv
source/i2c_sequencer.sv
source/i2c_master.sv
bench/i2c_clock_gen.sv
bench/i2c_target_model.sv
bench/i2c_master_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the I2C master testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f i2c_master.f --top-module i2c_master_tb \
    -Mdir obj_dir -o i2c_master_sim \
    && ./obj_dir/i2c_master_sim | tee sim.log

! grep -q "Verification failed" sim.log && grep -q "Verification passed" sim.log \
    || { echo "simulation FAILED"; exit 1; }

echo "simulation ok"
exit 0

// File: bench/i2c_stimulus.txt
# op dev reg data divider stretch ack expected (dev reg data expected in hex, stretch -1 is random)
# expected is the register after W, o_data after R, or the untouched register when not acked
W 42 10 a5 1 0 1 a5
R 42 10 00 1 0 1 a5
W 42 3c 5a 0 0 1 5a
R 42 3c 00 0 0 1 5a
W 43 10 ff 1 0 0 a5
R 42 10 00 3 0 1 a5
W 42 80 c3 2 5 1 c3
R 42 80 00 2 5 1 c3
W 42 81 3e 1 -1 1 3e
R 42 81 00 1 -1 1 3e
W 42 ff 01 7 0 1 01
R 42 ff 00 7 12 1 01
R 21 ff 00 2 0 0 01
W 42 00 7e 4 -1 1 7e
R 42 00 00 0 -1 1 7e
R 42 3c 00 5 3 1 5a
W 42 3c 96 0 20 1 96
R 42 3c 00 0 20 1 96
